// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f \
    --top-module tb_tengbaser_infrastructure -o sim_tb; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
  exit 0
fi
exit 1

// File: sources.f
+incdir+src
src/tengbaser_pkg.sv
src/tengbaser_qpll_ctrl.sv
src/tengbaser_gt_reset_seq.sv
src/tengbaser_reset_status.sv
src/tengbaser_infrastructure.sv
verification/tb_tengbaser_infrastructure.sv

// File: src/tengbaser_cfg.svh
`ifndef TENGBASER_CFG_SVH
`define TENGBASER_CFG_SVH

// settle time after rst before the PLL leaves reset
`define RESET_COUNTER_CYCLES 64

// wait for PLL lock or for transceiver reset-done
// a miss restarts the step
`define LOCK_TIMEOUT_CYCLES 256

// transceiver reset release to user-ready
`define TX_USERRDY_DELAY 8
`define RX_USERRDY_DELAY 4

`endif

// File: src/tengbaser_gt_reset_seq.sv
`timescale 1ns/1ps
`include "tengbaser_cfg.svh"

module tengbaser_gt_reset_seq import tengbaser_pkg::*; #(
  parameter int USERRDY_DELAY = 8
) (
  input  logic           clk156,
  input  logic           rst,
  input  qpll_status_t   qpll_status,
  input  logic           resetdone,
  output gt_seq_status_t seq_status
);

  // one counter covers both the user-ready delay and the reset-done timeout
  localparam int CNT_MAX = (`LOCK_TIMEOUT_CYCLES > USERRDY_DELAY) ?
                           `LOCK_TIMEOUT_CYCLES : USERRDY_DELAY;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  gt_seq_state_e    state;
  logic [CNT_W-1:0] cnt;
  logic             gtreset;
  logic             userrdy;
  logic             done;
  logic             retry_pulse;

  always_ff @(posedge clk156) begin
    if (rst) begin
      state       <= st_hold;
      cnt         <= '0;
      gtreset     <= 1'b1;
      userrdy     <= 1'b0;
      done        <= 1'b0;
      retry_pulse <= 1'b0;
    end else begin
      retry_pulse <= 1'b0;
      if (!qpll_status.ready) begin
        // PLL not usable, park everything
        state   <= st_hold;
        cnt     <= '0;
        gtreset <= 1'b1;
        userrdy <= 1'b0;
        done    <= 1'b0;
      end else begin
        case (state)
          // first start and retry both release here
          st_hold, st_release: begin
            gtreset <= 1'b0;
            cnt     <= '0;
            state   <= st_wait_ready;
          end
          st_wait_ready: begin
            // userrdy exactly USERRDY_DELAY cycles after gtreset falls
            if (cnt == CNT_W'(USERRDY_DELAY - 1)) begin
              userrdy <= 1'b1;
              cnt     <= '0;
              state   <= st_wait_done;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          st_wait_done: begin
            if (resetdone) begin
              done  <= 1'b1;
              state <= st_done;
            end else if (cnt == CNT_W'(`LOCK_TIMEOUT_CYCLES - 1)) begin
              // no reset-done, put the transceiver back in reset
              retry_pulse <= 1'b1;
              gtreset     <= 1'b1;
              userrdy     <= 1'b0;
              cnt         <= '0;
              state       <= st_release;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          // stays up until the PLL goes away
          st_done: begin
            state <= st_done;
          end
          default: begin
            state <= st_hold;
          end
        endcase
      end
    end
  end

  assign seq_status.gtreset     = gtreset;
  assign seq_status.userrdy     = userrdy;
  assign seq_status.done        = done;
  assign seq_status.retry_pulse = retry_pulse;

  // user logic never runs against a transceiver in reset
  a_userrdy_in_reset : assert property (@(posedge clk156) disable iff (rst)
    !(userrdy && gtreset));

  a_done_needs_userrdy : assert property (@(posedge clk156) disable iff (rst)
    done |-> userrdy);

endmodule

// File: src/tengbaser_infrastructure.sv
`timescale 1ns/1ps
`include "tengbaser_cfg.svh"

module tengbaser_infrastructure import tengbaser_pkg::*; (
  input  logic         clk156,
  input  logic         rst,
  input  logic         qplllock,
  input  logic         txresetdone,
  input  logic         rxresetdone,
  output logic         qpllreset,
  output logic         reset_counter_done,
  output logic         gttxreset,
  output logic         gtrxreset,
  output logic         txuserrdy,
  output logic         rxuserrdy,
  output logic         areset_clk156,
  output core_status_t core_status
);

  qpll_status_t   qpll_status;
  gt_seq_status_t tx_status;
  gt_seq_status_t rx_status;

  // PLL reset and lock
  tengbaser_qpll_ctrl qpll_ctrl_i (
    .clk156      (clk156),
    .rst         (rst),
    .qplllock    (qplllock),
    .qpllreset   (qpllreset),
    .qpll_status (qpll_status)
  );

  // tx and rx released side by side
  tengbaser_gt_reset_seq #(
    .USERRDY_DELAY (`TX_USERRDY_DELAY)
  ) tx_seq (
    .clk156      (clk156),
    .rst         (rst),
    .qpll_status (qpll_status),
    .resetdone   (txresetdone),
    .seq_status  (tx_status)
  );

  tengbaser_gt_reset_seq #(
    .USERRDY_DELAY (`RX_USERRDY_DELAY)
  ) rx_seq (
    .clk156      (clk156),
    .rst         (rst),
    .qpll_status (qpll_status),
    .resetdone   (rxresetdone),
    .seq_status  (rx_status)
  );

  tengbaser_reset_status reset_status_i (
    .clk156        (clk156),
    .rst           (rst),
    .qpll_status   (qpll_status),
    .tx_status     (tx_status),
    .rx_status     (rx_status),
    .areset_clk156 (areset_clk156),
    .core_status   (core_status)
  );

  // transceiver side levels
  assign reset_counter_done = qpll_status.counter_done;
  assign gttxreset          = tx_status.gtreset;
  assign gtrxreset          = rx_status.gtreset;
  assign txuserrdy          = tx_status.userrdy;
  assign rxuserrdy          = rx_status.userrdy;

endmodule

// File: src/tengbaser_pkg.sv
package tengbaser_pkg;

  // transceiver reset sequencer states
  // hold waits for the PLL, release is re-entered after a retry
  typedef enum logic [2:0] {
    st_hold       = 3'd0,
    st_release    = 3'd1,
    st_wait_ready = 3'd2,
    st_wait_done  = 3'd3,
    st_done       = 3'd4
  } gt_seq_state_e;

  // PLL control results
  typedef struct packed {
    // lock after the two-flop synchronizer
    logic lock;
    logic counter_done;
    // counter_done and lock together
    logic ready;
    // one cycle per lock timeout
    logic timeout_pulse;
  } qpll_status_t;

  // one direction's sequencer results
  typedef struct packed {
    logic gtreset;
    logic userrdy;
    logic done;
    // one cycle per reset-done timeout
    logic retry_pulse;
  } gt_seq_status_t;

  // core status byte, msb first
  typedef struct packed {
    // sticky
    logic qpll_timeout;
    // always zero
    logic reserved;
    // sticky
    logic rx_retry;
    // sticky
    logic tx_retry;
    logic rx_done;
    logic tx_done;
    logic counter_done;
    logic lock;
  } core_status_t;

endpackage

// File: src/tengbaser_qpll_ctrl.sv
`timescale 1ns/1ps
`include "tengbaser_cfg.svh"

module tengbaser_qpll_ctrl import tengbaser_pkg::*; (
  input  logic         clk156,
  input  logic         rst,
  input  logic         qplllock,
  output logic         qpllreset,
  output qpll_status_t qpll_status
);

  localparam int SETTLE_W  = $clog2(`RESET_COUNTER_CYCLES + 1);
  localparam int TIMEOUT_W = $clog2(`LOCK_TIMEOUT_CYCLES + 1);

  logic [SETTLE_W-1:0]  settle_cnt;
  logic                 counter_done;
  logic [TIMEOUT_W-1:0] timeout_cnt;
  logic                 timeout_pulse;
  logic                 lock_meta;
  logic                 lock_sync;
  logic                 was_ready;
  logic                 ready;
  logic                 lock_lost;
  logic                 lock_expired;
  logic                 restart;

  // qplllock comes from the PLL with no relation to clk156
  always_ff @(posedge clk156) begin
    if (rst) begin
      lock_meta <= 1'b0;
      lock_sync <= 1'b0;
    end else begin
      lock_meta <= qplllock;
      lock_sync <= lock_meta;
    end
  end

  assign ready = counter_done & lock_sync;

  // lock dropped after a completed bring-up
  assign lock_lost = was_ready & counter_done & ~lock_sync;

  // lock never came within the timeout
  assign lock_expired = counter_done & ~lock_sync & ~was_ready &
                        (timeout_cnt == TIMEOUT_W'(`LOCK_TIMEOUT_CYCLES - 1));

  // either case starts over from the settle counter
  assign restart = lock_lost | lock_expired;

  // settle counter, PLL reset follows it
  always_ff @(posedge clk156) begin
    if (rst || restart) begin
      settle_cnt   <= '0;
      counter_done <= 1'b0;
      qpllreset    <= 1'b1;
    end else if (!counter_done) begin
      // done and PLL reset release land on the same edge
      if (settle_cnt == SETTLE_W'(`RESET_COUNTER_CYCLES - 1)) begin
        counter_done <= 1'b1;
        qpllreset    <= 1'b0;
      end
      settle_cnt <= settle_cnt + 1'b1;
    end
  end

  // lock timeout, only runs before the first lock
  always_ff @(posedge clk156) begin
    if (rst || restart) begin
      timeout_cnt <= '0;
    end else if (counter_done && !lock_sync && !was_ready) begin
      timeout_cnt <= timeout_cnt + 1'b1;
    end else begin
      timeout_cnt <= '0;
    end
  end

  always_ff @(posedge clk156) begin
    if (rst) begin
      was_ready     <= 1'b0;
      timeout_pulse <= 1'b0;
    end else begin
      timeout_pulse <= lock_expired;
      if (restart) begin
        was_ready <= 1'b0;
      end else if (ready) begin
        was_ready <= 1'b1;
      end
    end
  end

  assign qpll_status.lock          = lock_sync;
  assign qpll_status.counter_done  = counter_done;
  assign qpll_status.ready         = ready;
  assign qpll_status.timeout_pulse = timeout_pulse;

  // PLL must be out of reset whenever the settle phase counts as done
  a_reset_vs_done : assert property (@(posedge clk156) disable iff (rst)
    !(qpllreset && counter_done));

endmodule

// File: src/tengbaser_reset_status.sv
`timescale 1ns/1ps

module tengbaser_reset_status import tengbaser_pkg::*; (
  input  logic           clk156,
  input  logic           rst,
  input  qpll_status_t   qpll_status,
  input  gt_seq_status_t tx_status,
  input  gt_seq_status_t rx_status,
  output logic           areset_clk156,
  output core_status_t   core_status
);

  logic tx_retry_seen;
  logic rx_retry_seen;
  logic qpll_timeout_seen;

  // core leaves reset only with both directions up
  always_ff @(posedge clk156) begin
    if (rst) begin
      areset_clk156 <= 1'b1;
    end else begin
      areset_clk156 <= ~(tx_status.done & rx_status.done);
    end
  end

  // sticky flags, cleared by rst only
  always_ff @(posedge clk156) begin
    if (rst) begin
      tx_retry_seen     <= 1'b0;
      rx_retry_seen     <= 1'b0;
      qpll_timeout_seen <= 1'b0;
    end else begin
      tx_retry_seen     <= tx_retry_seen | tx_status.retry_pulse;
      rx_retry_seen     <= rx_retry_seen | rx_status.retry_pulse;
      qpll_timeout_seen <= qpll_timeout_seen | qpll_status.timeout_pulse;
    end
  end

  // live bits straight through, sticky bits from the flags
  always_comb begin
    core_status.qpll_timeout = qpll_timeout_seen;
    core_status.reserved     = 1'b0;
    core_status.rx_retry     = rx_retry_seen;
    core_status.tx_retry     = tx_retry_seen;
    core_status.rx_done      = rx_status.done;
    core_status.tx_done      = tx_status.done;
    core_status.counter_done = qpll_status.counter_done;
    core_status.lock         = qpll_status.lock;
  end

  // lock loss reaches areset through the sequencers and this register,
  // so areset may stay low for two cycles after lock falls
  a_areset_needs_lock : assert property (@(posedge clk156) disable iff (rst)
    !areset_clk156 |-> $past(qpll_status.lock, 2));

endmodule

// File: verification/tb_tengbaser_infrastructure.sv
`timescale 1ns/1ps
`include "tengbaser_cfg.svh"

module tb_tengbaser_infrastructure import tengbaser_pkg::*;;

  localparam int NUM_TESTS = 5;
  localparam int FIELDS    = 5;

  logic         clk156      = 1'b0;
  logic         rst         = 1'b1;
  logic         qplllock    = 1'b0;
  logic         txresetdone = 1'b0;
  logic         rxresetdone = 1'b0;
  logic         qpllreset;
  logic         reset_counter_done;
  logic         gttxreset;
  logic         gtrxreset;
  logic         txuserrdy;
  logic         rxuserrdy;
  logic         areset_clk156;
  core_status_t core_status;

  // one scenario per row: lock, tx, rx delays, drop flag, expected status
  logic [15:0] stim [0:NUM_TESTS*FIELDS-1];

  // transceiver model settings for the running scenario
  int   lock_delay = 0;
  int   tx_delay   = 0;
  int   rx_delay   = 0;
  logic lock_kill  = 1'b0;
  int   lock_cnt   = 0;
  int   tx_cnt     = 0;
  int   rx_cnt     = 0;

  int errors = 0;
  int passed = 0;
  int failed = 0;

  tengbaser_infrastructure DUT (
    .clk156             (clk156),
    .rst                (rst),
    .qplllock           (qplllock),
    .txresetdone        (txresetdone),
    .rxresetdone        (rxresetdone),
    .qpllreset          (qpllreset),
    .reset_counter_done (reset_counter_done),
    .gttxreset          (gttxreset),
    .gtrxreset          (gtrxreset),
    .txuserrdy          (txuserrdy),
    .rxuserrdy          (rxuserrdy),
    .areset_clk156      (areset_clk156),
    .core_status        (core_status)
  );

  // 156.25 MHz stand-in, 40 ns period
  initial begin
    forever #20 clk156 = ~clk156;
  end

  // PLL model, locks once qpllreset has been low long enough
  always @(posedge clk156) begin
    if (qpllreset || lock_kill) begin
      lock_cnt <= 0;
      qplllock <= 1'b0;
    end else begin
      lock_cnt <= lock_cnt + 1;
      qplllock <= (lock_delay != 0) && (lock_cnt >= lock_delay);
    end
  end

  // tx reset-done follows gttxreset release
  always @(posedge clk156) begin
    if (gttxreset) begin
      tx_cnt      <= 0;
      txresetdone <= 1'b0;
    end else begin
      tx_cnt      <= tx_cnt + 1;
      txresetdone <= (tx_delay != 0) && (tx_cnt >= tx_delay);
    end
  end

  // rx side, delay 0 never completes
  always @(posedge clk156) begin
    if (gtrxreset) begin
      rx_cnt      <= 0;
      rxresetdone <= 1'b0;
    end else begin
      rx_cnt      <= rx_cnt + 1;
      rxresetdone <= (rx_delay != 0) && (rx_cnt >= rx_delay);
    end
  end

  task automatic check_status(input core_status_t got, input core_status_t exp,
                              input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // small spread on each nonzero model delay
  function automatic int add_jitter(input int base);
    if (base == 0) begin
      return 0;
    end
    return base + int'($urandom % 4);
  endfunction

  function automatic logic probe(input int which);
    case (which)
      0: return qpllreset;
      1: return reset_counter_done;
      2: return gttxreset;
      3: return gtrxreset;
      4: return txuserrdy;
      5: return rxuserrdy;
      default: return areset_clk156;
    endcase
  endfunction

  // counts falling edges until the level shows up, sampled mid-cycle
  task automatic wait_for(input int which, input logic value, input int limit,
                          input string name, output int cycles);
    cycles = 0;
    while (probe(which) !== value && cycles < limit) begin
      @(negedge clk156);
      cycles++;
    end
    if (probe(which) !== value) begin
      $display("timeout at %0t: %s did not reach %b within %0d cycles",
               $time, name, value, limit);
      errors++;
    end
  endtask

  // 4 cycles of rst, returns at the first sample after release
  task automatic apply_reset();
    @(posedge clk156);
    rst <= 1'b1;
    repeat (4) @(posedge clk156);
    rst <= 1'b0;
    @(negedge clk156);
  endtask

  task automatic run_scenario(input int idx);
    int           n;
    int           c_rx;
    int           c_tx;
    int           c_retry;
    int           first_errors;
    logic         drop;
    core_status_t expected;
    first_errors = errors;
    lock_delay   = add_jitter(int'(stim[idx*FIELDS]));
    tx_delay     = add_jitter(int'(stim[idx*FIELDS+1]));
    rx_delay     = add_jitter(int'(stim[idx*FIELDS+2]));
    drop         = stim[idx*FIELDS+3][0];
    expected     = core_status_t'(stim[idx*FIELDS+4][7:0]);
    lock_kill    = 1'b0;
    apply_reset();
    // values right after rst
    check_level(qpllreset, 1'b1, "qpllreset after rst");
    check_level(gttxreset, 1'b1, "gttxreset after rst");
    check_level(gtrxreset, 1'b1, "gtrxreset after rst");
    check_level(areset_clk156, 1'b1, "areset_clk156 after rst");
    check_level(txuserrdy, 1'b0, "txuserrdy after rst");
    check_level(rxuserrdy, 1'b0, "rxuserrdy after rst");
    check_level(reset_counter_done, 1'b0, "reset_counter_done after rst");
    // settle time, PLL reset drops with counter_done
    wait_for(0, 1'b0, `RESET_COUNTER_CYCLES + 10, "qpllreset low", n);
    check_count(n, `RESET_COUNTER_CYCLES, "settle cycles");
    check_level(reset_counter_done, 1'b1, "counter_done as qpllreset falls");
    if (lock_delay == 0) begin
      // no lock, controller restarts the PLL
      wait_for(0, 1'b1, `LOCK_TIMEOUT_CYCLES + 20, "qpllreset high again", n);
      check_count(n, `LOCK_TIMEOUT_CYCLES, "lock timeout cycles");
      repeat (2) @(negedge clk156);
      check_level(areset_clk156, 1'b1, "areset_clk156 without lock");
    end else begin
      wait_for(2, 1'b0, lock_delay + 20, "gttxreset low", n);
      check_level(gtrxreset, 1'b0, "gtrxreset with gttxreset");
      // rx delay is the shorter one
      wait_for(5, 1'b1, 20, "rxuserrdy", c_rx);
      check_count(c_rx, `RX_USERRDY_DELAY, "rx user-ready delay");
      wait_for(4, 1'b1, 20, "txuserrdy", c_tx);
      check_count(c_rx + c_tx, `TX_USERRDY_DELAY, "tx user-ready delay");
      if (rx_delay == 0) begin
        // timeout runs from rxuserrdy rising
        wait_for(3, 1'b1, `LOCK_TIMEOUT_CYCLES + 20, "gtrxreset high again", c_retry);
        check_count(c_tx + c_retry, `LOCK_TIMEOUT_CYCLES, "rx reset-done timeout");
        repeat (2) @(negedge clk156);
        check_level(areset_clk156, 1'b1, "areset_clk156 with rx down");
      end else begin
        wait_for(6, 1'b0, 200, "areset_clk156 low", n);
        if (drop) begin
          lock_kill = 1'b1;
          wait_for(6, 1'b1, 20, "areset_clk156 high after lock loss", n);
          check_level(gttxreset, 1'b1, "gttxreset after lock loss");
          check_level(gtrxreset, 1'b1, "gtrxreset after lock loss");
          lock_kill = 1'b0;
          // full restart, settle plus lock plus both reset-done
          wait_for(6, 1'b0, 400, "areset_clk156 low after relock", n);
        end
      end
    end
    check_status(core_status, expected, "core_status");
    if (errors == first_errors) begin
      passed++;
      $display("test %0d: ok", idx + 1);
    end else begin
      failed++;
      $display("test %0d: failed with %0d errors", idx + 1, errors - first_errors);
    end
  endtask

  initial begin
    void'($urandom(25));
    $readmemh("verification/tengbaser_stimulus.txt", stim);
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_scenario(i);
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verification/tengbaser_stimulus.txt
// columns: lock_delay tx_done_delay rx_done_delay drop_lock expected_core_status
// hex, delays in clk156 cycles, lock or rx delay of 0 never arrives
000a 0014 001e 0000 000f  // normal bring-up
000a 0014 0000 0000 0027  // rx reset-done missing, rx retry
0000 0014 001e 0000 0080  // lock missing, PLL timeout
000a 0014 001e 0001 000f  // lock drop after bring-up
0028 0032 000a 0000 000f  // slow lock, rx faster than tx
